// ==== verilog/armExecPkg.sv ====
`default_nettype none

package armExecPkg;

  // Data-processing opcodes, ARM bits [24:21]
  localparam logic [3:0] OpAnd = 4'b0000;
  localparam logic [3:0] OpEor = 4'b0001;
  localparam logic [3:0] OpSub = 4'b0010;
  localparam logic [3:0] OpRsb = 4'b0011;
  localparam logic [3:0] OpAdd = 4'b0100;
  localparam logic [3:0] OpAdc = 4'b0101;
  localparam logic [3:0] OpSbc = 4'b0110;
  localparam logic [3:0] OpRsc = 4'b0111;
  localparam logic [3:0] OpTst = 4'b1000; // Compare class is 10xx
  localparam logic [3:0] OpTeq = 4'b1001;
  localparam logic [3:0] OpCmp = 4'b1010;
  localparam logic [3:0] OpCmn = 4'b1011;
  localparam logic [3:0] OpOrr = 4'b1100;
  localparam logic [3:0] OpMov = 4'b1101;
  localparam logic [3:0] OpBic = 4'b1110;
  localparam logic [3:0] OpMvn = 4'b1111;

  // Condition field, bits [31:28]
  localparam logic [3:0] CondEq = 4'h0;
  localparam logic [3:0] CondNe = 4'h1;
  localparam logic [3:0] CondCs = 4'h2;
  localparam logic [3:0] CondCc = 4'h3;
  localparam logic [3:0] CondMi = 4'h4;
  localparam logic [3:0] CondPl = 4'h5;
  localparam logic [3:0] CondVs = 4'h6;
  localparam logic [3:0] CondVc = 4'h7;
  localparam logic [3:0] CondHi = 4'h8;
  localparam logic [3:0] CondLs = 4'h9;
  localparam logic [3:0] CondGe = 4'ha;
  localparam logic [3:0] CondLt = 4'hb;
  localparam logic [3:0] CondGt = 4'hc;
  localparam logic [3:0] CondLe = 4'hd;
  localparam logic [3:0] CondAl = 4'he;
  localparam logic [3:0] CondNv = 4'hf; // Never issued

  localparam logic [1:0] ShLsl = 2'b00;
  localparam logic [1:0] ShLsr = 2'b01;
  localparam logic [1:0] ShAsr = 2'b10;
  localparam logic [1:0] ShRor = 2'b11;

  // Bit positions inside NZCV
  localparam int FlagN = 3;
  localparam int FlagZ = 2;
  localparam int FlagC = 1;
  localparam int FlagV = 0;

  // Operand 2 field, bits [11:0], read per the I bit
  typedef union packed {
    struct packed {
      logic [3:0] rotate; // ROR by twice this
      logic [7:0] imm8;
    } imm;
    struct packed {
      logic [4:0] shAmt;
      logic [1:0] shType;
      logic       zero;   // Set means register-amount shift
      logic [3:0] rm;
    } shReg;
  } operand2U;

endpackage

`default_nettype wire

// ==== verilog/operandDecode.sv ====
`default_nettype none

module operandDecode (
  input  logic                immOp,    // I bit
  input  armExecPkg::operand2U operand2,
  input  logic         [31:0] rmVal,    // Rm already read
  output logic         [31:0] shiftSrc,
  output logic          [4:0] shiftAmt,
  output logic          [1:0] shiftType,
  output logic                isRrx
);

  always_comb begin
    if (immOp) begin
      // Rotated immediate
      shiftSrc  = {24'b0, operand2.imm.imm8};
      shiftAmt  = {operand2.imm.rotate, 1'b0}; // Even rotations only
      shiftType = armExecPkg::ShRor;
      isRrx     = 1'b0;                        // ROR #0 here is a plain copy
    end else begin
      // Immediate-shifted register
      shiftSrc  = rmVal;
      shiftAmt  = operand2.shReg.shAmt;
      shiftType = operand2.shReg.shType;
      // ROR #0 is the RRX encoding
      isRrx     = (operand2.shReg.shType == armExecPkg::ShRor) &&
                  (operand2.shReg.shAmt == 5'd0);
    end
    // LSR #0 and ASR #0 stay as amount 0 with their type
    // The shifter reads them as shifts by 32
  end

  // Register-amount shifts are not supported by this stage
  always_comb begin
    assert final (immOp || !operand2.shReg.zero)
      else $error("register-specified shift issued to execute stage");
  end

endmodule

`default_nettype wire

// ==== verilog/barrelShifter.sv ====
`default_nettype none

module barrelShifter (
  input  logic [31:0] shiftSrc,
  input  logic  [4:0] shiftAmt,   // 0..31 as encoded
  input  logic  [1:0] shiftType,
  input  logic        isRrx,
  input  logic        carryIn,    // Current C flag
  output logic [31:0] shiftOut,
  output logic        shiftCarry
);

  logic  [5:0] amtLong;   // LSR/ASR amount, 0 read as 32
  logic [32:0] lslVal;    // {carry, result}
  logic [32:0] lsrVal;    // {result, carry}
  logic [32:0] asrVal;    // {result, carry}
  logic [63:0] rorVal;

  assign amtLong = (shiftAmt == 5'd0) ? 6'd32 : {1'b0, shiftAmt};

  // Last bit out lands in the spare position
  assign lslVal = {1'b0, shiftSrc} << shiftAmt;
  assign lsrVal = {shiftSrc, 1'b0} >> amtLong;
  assign asrVal = $signed({shiftSrc, 1'b0}) >>> amtLong; // Sign fill from bit 31
  assign rorVal = {shiftSrc, shiftSrc} >> shiftAmt;

  always_comb begin
    shiftOut   = shiftSrc; // Amount 0 default
    shiftCarry = carryIn;
    if (isRrx) begin
      // 33-bit rotate through carry
      shiftOut   = {carryIn, shiftSrc[31:1]};
      shiftCarry = shiftSrc[0];
    end else begin
      case (shiftType)
        armExecPkg::ShLsl: begin
          if (shiftAmt != 5'd0) begin // LSL #0 keeps C
            shiftOut   = lslVal[31:0];
            shiftCarry = lslVal[32];
          end
        end
        armExecPkg::ShLsr: begin
          shiftOut   = lsrVal[32:1];
          shiftCarry = lsrVal[0];     // Bit 31 when shifting by 32
        end
        armExecPkg::ShAsr: begin
          shiftOut   = asrVal[32:1];
          shiftCarry = asrVal[0];
        end
        default: begin                // ROR
          if (shiftAmt != 5'd0) begin // Unrotated immediate keeps C
            shiftOut   = rorVal[31:0];
            shiftCarry = rorVal[31];
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/aluUnit.sv ====
`default_nettype none

module aluUnit (
  input  logic  [3:0] opcode,
  input  logic [31:0] a,         // Rn
  input  logic [31:0] b,         // Shifter output
  input  logic        carryIn,   // Current C flag
  output logic [31:0] aluResult,
  output logic  [3:0] aluFlags   // Raw NZCV
);

  logic [31:0] addA;
  logic [31:0] addB;
  logic        addCin;
  logic [32:0] sum;
  logic        overflow;

  // Single adder, subtracts go through inversion
  always_comb begin
    addA   = a;
    addB   = b;
    addCin = 1'b0;
    case (opcode)
      armExecPkg::OpSub, armExecPkg::OpCmp: begin
        addB   = ~b;
        addCin = 1'b1;      // a - b
      end
      armExecPkg::OpRsb: begin
        addA   = ~a;
        addCin = 1'b1;      // b - a
      end
      armExecPkg::OpAdc: addCin = carryIn;
      armExecPkg::OpSbc: begin
        addB   = ~b;
        addCin = carryIn;   // a - b - !C
      end
      armExecPkg::OpRsc: begin
        addA   = ~a;
        addCin = carryIn;
      end
      default: ;            // ADD, CMN, logic ops
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} + {32'b0, addCin};
  // Same-sign inputs with a different-sign sum
  assign overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);

  always_comb begin
    case (opcode)
      armExecPkg::OpAnd, armExecPkg::OpTst: aluResult = a & b;
      armExecPkg::OpEor, armExecPkg::OpTeq: aluResult = a ^ b;
      armExecPkg::OpOrr:                    aluResult = a | b;
      armExecPkg::OpMov:                    aluResult = b;
      armExecPkg::OpBic:                    aluResult = a & ~b;
      armExecPkg::OpMvn:                    aluResult = ~b;
      default:                              aluResult = sum[31:0];
    endcase
  end

  // C and V only meaningful for arithmetic opcodes
  always_comb begin
    aluFlags[armExecPkg::FlagN] = aluResult[31];
    aluFlags[armExecPkg::FlagZ] = (aluResult == 32'd0);
    aluFlags[armExecPkg::FlagC] = sum[32];  // Not-borrow on subtracts
    aluFlags[armExecPkg::FlagV] = overflow;
  end

endmodule

`default_nettype wire

// ==== verilog/conditional.sv ====
`default_nettype none

module conditional (
  input  logic [3:0] cond,
  input  logic [3:0] opcode,
  input  logic [3:0] flags,      // Current NZCV
  input  logic [3:0] aluFlags,   // NZCV from the ALU
  input  logic       shiftCarry, // Shifter carry-out
  input  logic       setFlags,   // S bit
  output logic       condEx,
  output logic [3:0] flagsNext
);

  logic neg;
  logic zero;
  logic carry;
  logic overflow;
  logic ge;
  logic isLogic;
  logic carryNext;
  logic overflowNext;
  logic update;

  assign neg      = flags[armExecPkg::FlagN];
  assign zero     = flags[armExecPkg::FlagZ];
  assign carry    = flags[armExecPkg::FlagC];
  assign overflow = flags[armExecPkg::FlagV];
  assign ge       = (neg == overflow); // Signed greater or equal

  always_comb begin
    case (cond)
      armExecPkg::CondEq: condEx = zero;
      armExecPkg::CondNe: condEx = ~zero;
      armExecPkg::CondCs: condEx = carry;
      armExecPkg::CondCc: condEx = ~carry;
      armExecPkg::CondMi: condEx = neg;
      armExecPkg::CondPl: condEx = ~neg;
      armExecPkg::CondVs: condEx = overflow;
      armExecPkg::CondVc: condEx = ~overflow;
      armExecPkg::CondHi: condEx = carry & ~zero;    // Unsigned higher
      armExecPkg::CondLs: condEx = ~carry | zero;
      armExecPkg::CondGe: condEx = ge;
      armExecPkg::CondLt: condEx = ~ge;
      armExecPkg::CondGt: condEx = ~zero & ge;
      armExecPkg::CondLe: condEx = zero | ~ge;
      armExecPkg::CondAl: condEx = 1'b1;
      default:            condEx = 1'b0;             // NV never executes
    endcase
  end

  // Logic class takes C from the shifter
  always_comb begin
    case (opcode)
      armExecPkg::OpAnd, armExecPkg::OpEor, armExecPkg::OpTst, armExecPkg::OpTeq,
      armExecPkg::OpOrr, armExecPkg::OpMov, armExecPkg::OpBic, armExecPkg::OpMvn:
        isLogic = 1'b1;
      default:
        isLogic = 1'b0;
    endcase
  end

  assign carryNext    = isLogic ? shiftCarry : aluFlags[armExecPkg::FlagC];
  assign overflowNext = isLogic ? overflow   : aluFlags[armExecPkg::FlagV]; // V untouched by logic ops

  // Flags only move when the instruction executes with S set
  assign update = setFlags & condEx;

  always_comb begin
    if (update) begin
      flagsNext[armExecPkg::FlagN] = aluFlags[armExecPkg::FlagN];
      flagsNext[armExecPkg::FlagZ] = aluFlags[armExecPkg::FlagZ];
      flagsNext[armExecPkg::FlagC] = carryNext;
      flagsNext[armExecPkg::FlagV] = overflowNext;
    end else begin
      flagsNext = flags;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`default_nettype none

module executeStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 instrValid,
  input  logic           [3:0] cond,
  input  logic           [3:0] opcode,
  input  logic                 setFlags,   // S bit
  input  logic                 immOp,      // I bit
  input  armExecPkg::operand2U operand2,
  input  logic          [31:0] rnVal,
  input  logic          [31:0] rmVal,
  output logic                 resultValid,
  output logic          [31:0] result,
  output logic                 condPassed,
  output logic                 writesResult,
  output logic           [3:0] flags       // Architectural NZCV
);

  logic [31:0] shiftSrc;
  logic  [4:0] shiftAmt;
  logic  [1:0] shiftType;
  logic        isRrx;
  logic [31:0] shiftOut;
  logic        shiftCarry;
  logic [31:0] aluResult;
  logic  [3:0] aluFlags;
  logic        condEx;
  logic  [3:0] flagsNext;
  logic        isCompare;

  operandDecode i_operandDecode (
    .immOp     (immOp),
    .operand2  (operand2),
    .rmVal     (rmVal),
    .shiftSrc  (shiftSrc),
    .shiftAmt  (shiftAmt),
    .shiftType (shiftType),
    .isRrx     (isRrx)
  );

  barrelShifter i_barrelShifter (
    .shiftSrc   (shiftSrc),
    .shiftAmt   (shiftAmt),
    .shiftType  (shiftType),
    .isRrx      (isRrx),
    .carryIn    (flags[armExecPkg::FlagC]), // Also feeds RRX
    .shiftOut   (shiftOut),
    .shiftCarry (shiftCarry)
  );

  aluUnit i_aluUnit (
    .opcode    (opcode),
    .a         (rnVal),
    .b         (shiftOut),
    .carryIn   (flags[armExecPkg::FlagC]),
    .aluResult (aluResult),
    .aluFlags  (aluFlags)
  );

  conditional i_conditional (
    .cond       (cond),
    .opcode     (opcode),
    .flags      (flags),      // Register read straight through
    .aluFlags   (aluFlags),
    .shiftCarry (shiftCarry),
    .setFlags   (setFlags),
    .condEx     (condEx),
    .flagsNext  (flagsNext)
  );

  // TST, TEQ, CMP, CMN
  assign isCompare = (opcode[3:2] == armExecPkg::OpTst[3:2]);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= 4'b0000;
    end else if (instrValid) begin
      flags <= flagsNext;        // Next instruction sees these
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultValid  <= 1'b0;
      condPassed   <= 1'b0;
      writesResult <= 1'b0;
    end else begin
      resultValid  <= instrValid;
      condPassed   <= instrValid & condEx;
      writesResult <= instrValid & condEx & ~isCompare;
    end
  end

  always_ff @(posedge clk) begin
    result <= aluResult;         // Qualified by resultValid
  end

  // NV is reserved
  assert property (@(posedge clk) disable iff (!rstN)
    instrValid |-> (cond != armExecPkg::CondNv))
    else $error("NV condition issued");

  // Without S the whole path must leave NZCV alone
  assert property (@(posedge clk) disable iff (!rstN)
    (instrValid && !setFlags) |=> $stable(flags))
    else $error("flags changed without S bit");

endmodule

`default_nettype wire

// ==== dv/execVectors.svh ====
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// Each row holds valid, cond, opcode, S, I, operand2, rnVal
//   then rmVal, result, condPassed, writesResult and NZCV after the row
typedef struct packed {
  logic        valid;
  logic  [3:0] cond;
  logic  [3:0] opcode;
  logic        setFlags;
  logic        immOp;
  logic [11:0] operand2;      // Raw field in imm or shReg layout
  logic [31:0] rnVal;
  logic [31:0] rmVal;
  logic [31:0] expResult;     // Registered even when the condition fails
  logic        expCondPassed;
  logic        expWrites;
  logic  [3:0] expFlags;      // NZCV
} vectorT;

localparam int NumVectors = 28;

vectorT vectors [NumVectors] = '{
  // Flags start at 0000
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpMov, 1'b1, 1'b1, 12'h4ff, 32'h0,
    32'h0, 32'hff000000, 1'b1, 1'b1, 4'ha},          // 0xff ror 8 with C from bit 31
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpAdd, 1'b1, 1'b0, 12'h001, 32'h7fffffff,
    32'h1, 32'h80000000, 1'b1, 1'b1, 4'h9},          // Signed overflow
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpSub, 1'b1, 1'b0, 12'h001, 32'h0,
    32'h1, 32'hffffffff, 1'b1, 1'b1, 4'h8},          // Borrow clears C
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpAdd, 1'b1, 1'b0, 12'h001, 32'hffffffff,
    32'h1, 32'h0, 1'b1, 1'b1, 4'h6},                 // Carry out and zero
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpAdc, 1'b0, 1'b0, 12'h001, 32'h5,
    32'h3, 32'h9, 1'b1, 1'b1, 4'h6},                 // 5 + 3 + stored C without S
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpAdc, 1'b1, 1'b0, 12'h001, 32'h10,
    32'h20, 32'h31, 1'b1, 1'b1, 4'h0},
  // CMP of 5 and 3 leaves N0 Z0 C1 V0
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpCmp, 1'b1, 1'b0, 12'h001, 32'h5,
    32'h3, 32'h2, 1'b1, 1'b0, 4'h2},
  '{1'b1, armExecPkg::CondEq, armExecPkg::OpMov, 1'b1, 1'b1, 12'h000, 32'h0,
    32'h0, 32'h0, 1'b0, 1'b0, 4'h2},                 // Fails so S has no effect
  '{1'b1, armExecPkg::CondNe, armExecPkg::OpMov, 1'b0, 1'b1, 12'h002, 32'h0,
    32'h0, 32'h2, 1'b1, 1'b1, 4'h2},
  '{1'b1, armExecPkg::CondCs, armExecPkg::OpMov, 1'b0, 1'b1, 12'h003, 32'h0,
    32'h0, 32'h3, 1'b1, 1'b1, 4'h2},
  '{1'b1, armExecPkg::CondHi, armExecPkg::OpMov, 1'b0, 1'b1, 12'h004, 32'h0,
    32'h0, 32'h4, 1'b1, 1'b1, 4'h2},
  '{1'b1, armExecPkg::CondGe, armExecPkg::OpMov, 1'b0, 1'b1, 12'h005, 32'h0,
    32'h0, 32'h5, 1'b1, 1'b1, 4'h2},
  '{1'b1, armExecPkg::CondLt, armExecPkg::OpMov, 1'b0, 1'b1, 12'h006, 32'h0,
    32'h0, 32'h6, 1'b0, 1'b0, 4'h2},
  '{1'b1, armExecPkg::CondGt, armExecPkg::OpMov, 1'b0, 1'b1, 12'h007, 32'h0,
    32'h0, 32'h7, 1'b1, 1'b1, 4'h2},
  '{1'b1, armExecPkg::CondLe, armExecPkg::OpMov, 1'b0, 1'b1, 12'h008, 32'h0,
    32'h0, 32'h8, 1'b0, 1'b0, 4'h2},
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpMov, 1'b0, 1'b1, 12'h009, 32'h0,
    32'h0, 32'h9, 1'b1, 1'b1, 4'h2},
  // CMP of 3 and 5 gives a negative difference with borrow
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpCmp, 1'b1, 1'b0, 12'h001, 32'h3,
    32'h5, 32'hfffffffe, 1'b1, 1'b0, 4'h8},
  '{1'b1, armExecPkg::CondLt, armExecPkg::OpMov, 1'b0, 1'b1, 12'h00a, 32'h0,
    32'h0, 32'ha, 1'b1, 1'b1, 4'h8},                 // Back to back on CMP flags
  '{1'b1, armExecPkg::CondGt, armExecPkg::OpMov, 1'b0, 1'b1, 12'h00b, 32'h0,
    32'h0, 32'hb, 1'b0, 1'b0, 4'h8},
  '{1'b1, armExecPkg::CondLe, armExecPkg::OpMov, 1'b0, 1'b1, 12'h00c, 32'h0,
    32'h0, 32'hc, 1'b1, 1'b1, 4'h8},
  // Bubble where flags must hold even with S
  '{1'b0, armExecPkg::CondAl, armExecPkg::OpMov, 1'b1, 1'b1, 12'h0ee, 32'h0,
    32'h0, 32'hee, 1'b0, 1'b0, 4'h8},
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpAdd, 1'b1, 1'b0, 12'h001, 32'h7fffffff,
    32'h1, 32'h80000000, 1'b1, 1'b1, 4'h9},          // Sets V for the logic rows
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpAnd, 1'b1, 1'b0, 12'h202, 32'hf0f0f0f0,
    32'h1ff00000, 32'hf0000000, 1'b1, 1'b1, 4'hb},   // LSL #4 moves bit 28 into C
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpMov, 1'b1, 1'b0, 12'h064, 32'h0,
    32'h2, 32'h80000001, 1'b1, 1'b1, 4'h9},          // RRX puts old C into bit 31
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpOrr, 1'b1, 1'b0, 12'h023, 32'h0,
    32'h80000000, 32'h0, 1'b1, 1'b1, 4'h7},          // LSR #32 takes C from bit 31
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpTst, 1'b1, 1'b1, 12'h0f0, 32'hf0,
    32'h0, 32'hf0, 1'b1, 1'b0, 4'h3},                // Unrotated imm keeps C
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpCmn, 1'b1, 1'b1, 12'h001, 32'hffffffff,
    32'h0, 32'h0, 1'b1, 1'b0, 4'h6},
  '{1'b1, armExecPkg::CondAl, armExecPkg::OpAdd, 1'b0, 1'b0, 12'h001, 32'h7fffffff,
    32'h1, 32'h80000000, 1'b1, 1'b1, 4'h6}           // Overflow ignored without S
};

`endif

// ==== dv/executeStageTb.sv ====
`default_nettype none

module executeStageTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetCycles = 5;

  logic                 clk;
  logic                 rstN;
  logic                 instrValid;
  logic           [3:0] cond;
  logic           [3:0] opcode;
  logic                 setFlags;
  logic                 immOp;
  armExecPkg::operand2U operand2;
  logic          [31:0] rnVal;
  logic          [31:0] rmVal;
  logic                 resultValid;
  logic          [31:0] result;
  logic                 condPassed;
  logic                 writesResult;
  logic           [3:0] flags;
  int                   cycleCount = 0;
  int                   rowIndex;   // Row under check, -1 right after reset

  `include "execVectors.svh"

  // Table rows plus reset plus slack
  localparam int CycleLimit = NumVectors + ResetCycles + 20;

  executeStage i_executeStage (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .cond         (cond),
    .opcode       (opcode),
    .setFlags     (setFlags),
    .immOp        (immOp),
    .operand2     (operand2),
    .rnVal        (rnVal),
    .rmVal        (rmVal),
    .resultValid  (resultValid),
    .result       (result),
    .condPassed   (condPassed),
    .writesResult (writesResult),
    .flags        (flags)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d cycles, vector table did not complete", cycleCount);
      $display("TESTS FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error %s got %h expected %h", name, got, expected);
      if (rowIndex >= 0) begin
        $display("Mismatch seen on vector %0d", rowIndex);
      end
      $display("TESTS FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic applyVector(input int idx);
    instrValid = vectors[idx].valid;
    cond       = vectors[idx].cond;
    opcode     = vectors[idx].opcode;
    setFlags   = vectors[idx].setFlags;
    immOp      = vectors[idx].immOp;
    operand2   = vectors[idx].operand2; // Union read per immOp inside the DUT
    rnVal      = vectors[idx].rnVal;
    rmVal      = vectors[idx].rmVal;
  endtask

  // One edge after the row was sampled
  task automatic checkOutputs(input int idx);
    rowIndex = idx;
    compareValue("resultValid", 32'(resultValid), 32'(vectors[idx].valid));
    compareValue("result", result, vectors[idx].expResult);
    compareValue("condPassed", 32'(condPassed), 32'(vectors[idx].expCondPassed));
    compareValue("writesResult", 32'(writesResult), 32'(vectors[idx].expWrites));
    compareValue("flags", 32'(flags), 32'(vectors[idx].expFlags));
  endtask

  initial begin
    rstN       = 1'b0;
    instrValid = 1'b0;
    cond       = armExecPkg::CondAl;
    opcode     = armExecPkg::OpMov;
    setFlags   = 1'b0;
    immOp      = 1'b0;
    operand2   = '0;
    rnVal      = '0;
    rmVal      = '0;
    rowIndex   = -1;

    repeat (ResetCycles) @(posedge clk);
    #2;
    rstN = 1'b1;

    // Reset state before any instruction
    compareValue("flags", 32'(flags), 32'h0);
    compareValue("resultValid", 32'(resultValid), 32'h0);
    compareValue("condPassed", 32'(condPassed), 32'h0);
    compareValue("writesResult", 32'(writesResult), 32'h0);

    // Drive row i and check row i-1 in the same slot
    for (int i = 0; i <= NumVectors; i++) begin
      @(posedge clk);
      #2;
      if (i > 0) begin
        checkOutputs(i - 1);
      end
      if (i < NumVectors) begin
        applyVector(i);
      end else begin
        instrValid = 1'b0;               // Drain, nothing left to issue
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
verilog/armExecPkg.sv
verilog/operandDecode.sv
verilog/barrelShifter.sv
verilog/aluUnit.sv
verilog/conditional.sv
verilog/executeStage.sv
dv/executeStageTb.sv

// ==== Makefile ====
# Verilator build for the execute stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module executeStageTb -Mdir obj_dir

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./obj_dir/VexecuteStageTb

clean:
	rm -rf obj_dir
